//--- design/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define CPU_WIDTH       64
`define INST_WIDTH      32
`define EXU_SEL_WIDTH   3
`define EXU_OPT_WIDTH   5

`define EXU_SEL_REG     3'd0
`define EXU_SEL_IMM     3'd1
`define EXU_SEL_PC4     3'd2
`define EXU_SEL_PCI     3'd3
`define EXU_SEL_LUI     3'd4

`define EXU_ADD         5'd0
`define EXU_SUB         5'd1
`define EXU_ADDW        5'd2
`define EXU_SUBW        5'd3
`define EXU_AND         5'd4
`define EXU_OR          5'd5
`define EXU_XOR         5'd6
`define EXU_SLL         5'd7
`define EXU_SRL         5'd8
`define EXU_SRA         5'd9
`define EXU_SLLW        5'd10
`define EXU_SRLW        5'd11
`define EXU_SRAW        5'd12
`define EXU_SLT         5'd13
`define EXU_SLTU        5'd14
`define EXU_MUL         5'd15
`define EXU_MULH        5'd16
`define EXU_MULHSU      5'd17
`define EXU_MULHU       5'd18
`define EXU_DIV         5'd19
`define EXU_DIVU        5'd20
`define EXU_REM         5'd21
`define EXU_REMU        5'd22
`define EXU_MULW        5'd23
`define EXU_DIVW        5'd24
`define EXU_DIVUW       5'd25
`define EXU_REMW        5'd26
`define EXU_REMUW       5'd27
`define EXU_NOP         5'd31

`endif

//--- design/isa_pkg.sv
`include "cpu_defines.svh"

package isa_pkg;

  typedef logic [`CPU_WIDTH-1:0]  word_t;
  typedef logic [`INST_WIDTH-1:0] inst_word_t;
  typedef logic [4:0]             reg_idx_t;
  typedef logic [2:0]             funct3_t;
  typedef logic [6:0]             funct7_t;

  // Major opcodes handled by the execute path
  typedef enum logic [6:0] {
    OPC_OP        = 7'b0110011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP_32     = 7'b0111011,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_LUI       = 7'b0110111,
    OPC_AUIPC     = 7'b0010111,
    OPC_JAL       = 7'b1101111,
    OPC_JALR      = 7'b1100111
  } opcode_e;

  typedef struct packed {
    funct7_t  funct7;
    reg_idx_t rs2;
    reg_idx_t rs1;
    funct3_t  funct3;
    reg_idx_t rd;
    opcode_e  opcode;   // Bits 6:0 of the word
  } inst_t;

endpackage

//--- design/exu_pkg.sv
`include "cpu_defines.svh"

package exu_pkg;

  typedef enum logic [`EXU_SEL_WIDTH-1:0] {
    SEL_REG = `EXU_SEL_REG,   // rs1 and rs2
    SEL_IMM = `EXU_SEL_IMM,   // rs1 and immediate
    SEL_PC4 = `EXU_SEL_PC4,   // PC and 4, the link value
    SEL_PCI = `EXU_SEL_PCI,   // PC and immediate
    SEL_LUI = `EXU_SEL_LUI    // Zero and immediate
  } exu_src_e;

  typedef enum logic [`EXU_OPT_WIDTH-1:0] {
    OP_ADD    = `EXU_ADD,
    OP_SUB    = `EXU_SUB,
    OP_ADDW   = `EXU_ADDW,
    OP_SUBW   = `EXU_SUBW,
    OP_AND    = `EXU_AND,
    OP_OR     = `EXU_OR,
    OP_XOR    = `EXU_XOR,
    OP_SLL    = `EXU_SLL,
    OP_SRL    = `EXU_SRL,
    OP_SRA    = `EXU_SRA,
    OP_SLLW   = `EXU_SLLW,
    OP_SRLW   = `EXU_SRLW,
    OP_SRAW   = `EXU_SRAW,
    OP_SLT    = `EXU_SLT,
    OP_SLTU   = `EXU_SLTU,
    OP_MUL    = `EXU_MUL,
    OP_MULH   = `EXU_MULH,
    OP_MULHSU = `EXU_MULHSU,
    OP_MULHU  = `EXU_MULHU,
    OP_DIV    = `EXU_DIV,
    OP_DIVU   = `EXU_DIVU,
    OP_REM    = `EXU_REM,
    OP_REMU   = `EXU_REMU,
    OP_MULW   = `EXU_MULW,
    OP_DIVW   = `EXU_DIVW,
    OP_DIVUW  = `EXU_DIVUW,
    OP_REMW   = `EXU_REMW,
    OP_REMUW  = `EXU_REMUW,
    OP_NOP    = `EXU_NOP
  } exu_op_e;

  typedef struct packed {
    exu_src_e          src;
    exu_op_e           op;
    isa_pkg::word_t    imm;   // Already sign-extended
    isa_pkg::reg_idx_t rd;
    logic              wen;
  } exu_req_t;

endpackage

//--- design/stl_mux_default.sv
`timescale 1ns/100ps

module stl_mux_default #(
  parameter int NR_KEY   = 2,
  parameter int KEY_LEN  = 1,
  parameter int DATA_LEN = 1
) (
  output logic [DATA_LEN-1:0]                  o_out,
  input  logic [KEY_LEN-1:0]                   i_key,
  input  logic [DATA_LEN-1:0]                  i_default,
  input  logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] i_lut
);

  localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

  // Each pair is {key, value}, the first pair of the list sits at the top
  always_comb begin
    o_out = i_default;
    for (int i = 0; i < NR_KEY; i++) begin
      if (i_lut[i*PAIR_LEN+DATA_LEN +: KEY_LEN] == i_key) begin
        o_out = i_lut[i*PAIR_LEN +: DATA_LEN];   // Earlier pair wins on a duplicate key
      end
    end
  end

endmodule

//--- design/idu_decode.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module idu_decode (
  input  isa_pkg::inst_t    i_inst,
  output exu_pkg::exu_req_t o_req
);

  localparam isa_pkg::funct7_t F7_BASE   = 7'b0000000;
  localparam isa_pkg::funct7_t F7_ALT    = 7'b0100000;
  localparam isa_pkg::funct7_t F7_MULDIV = 7'b0000001;

  isa_pkg::inst_word_t raw;
  isa_pkg::word_t      imm_i;
  isa_pkg::word_t      imm_u;
  isa_pkg::word_t      imm_j;
  isa_pkg::word_t      shamt6;
  isa_pkg::word_t      shamt5;
  exu_pkg::exu_src_e   src;
  exu_pkg::exu_op_e    op;
  isa_pkg::word_t      imm;

  function automatic exu_pkg::exu_op_e base_op(input isa_pkg::funct3_t f3);
    case (f3)
      3'b000:  return exu_pkg::OP_ADD;
      3'b001:  return exu_pkg::OP_SLL;
      3'b010:  return exu_pkg::OP_SLT;
      3'b011:  return exu_pkg::OP_SLTU;
      3'b100:  return exu_pkg::OP_XOR;
      3'b101:  return exu_pkg::OP_SRL;
      3'b110:  return exu_pkg::OP_OR;
      default: return exu_pkg::OP_AND;
    endcase
  endfunction

  function automatic exu_pkg::exu_op_e muldiv_op(input isa_pkg::funct3_t f3);
    case (f3)
      3'b000:  return exu_pkg::OP_MUL;
      3'b001:  return exu_pkg::OP_MULH;
      3'b010:  return exu_pkg::OP_MULHSU;
      3'b011:  return exu_pkg::OP_MULHU;
      3'b100:  return exu_pkg::OP_DIV;
      3'b101:  return exu_pkg::OP_DIVU;
      3'b110:  return exu_pkg::OP_REM;
      default: return exu_pkg::OP_REMU;
    endcase
  endfunction

  assign raw    = i_inst;
  assign imm_i  = {{(`CPU_WIDTH-12){raw[31]}}, raw[31:20]};
  assign imm_u  = {{(`CPU_WIDTH-32){raw[31]}}, raw[31:12], 12'b0};
  assign imm_j  = {{(`CPU_WIDTH-21){raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
  assign shamt6 = {{(`CPU_WIDTH-6){1'b0}}, raw[25:20]};
  assign shamt5 = {{(`CPU_WIDTH-5){1'b0}}, raw[24:20]};

  always_comb begin
    src = exu_pkg::SEL_REG;
    op  = exu_pkg::OP_NOP;   // Anything not matched below stays a NOP
    imm = '0;
    case (i_inst.opcode)
      isa_pkg::OPC_OP: begin
        if (i_inst.funct7 == F7_BASE) begin
          op = base_op(i_inst.funct3);
        end else if (i_inst.funct7 == F7_MULDIV) begin
          op = muldiv_op(i_inst.funct3);
        end else if (i_inst.funct7 == F7_ALT && i_inst.funct3 == 3'b000) begin
          op = exu_pkg::OP_SUB;
        end else if (i_inst.funct7 == F7_ALT && i_inst.funct3 == 3'b101) begin
          op = exu_pkg::OP_SRA;
        end
      end
      isa_pkg::OPC_OP_IMM: begin
        src = exu_pkg::SEL_IMM;
        imm = imm_i;
        if (i_inst.funct3 == 3'b001 || i_inst.funct3 == 3'b101) begin
          imm = shamt6;   // RV64 shifts carry funct6 above a 6-bit shamt
          if (raw[31:26] == 6'b000000 && i_inst.funct3 == 3'b001) begin
            op = exu_pkg::OP_SLL;
          end else if (raw[31:26] == 6'b000000) begin
            op = exu_pkg::OP_SRL;
          end else if (raw[31:26] == 6'b010000 && i_inst.funct3 == 3'b101) begin
            op = exu_pkg::OP_SRA;
          end
        end else begin
          op = base_op(i_inst.funct3);
        end
      end
      isa_pkg::OPC_OP_32: begin
        case ({i_inst.funct7, i_inst.funct3})
          {F7_BASE, 3'b000}:   op = exu_pkg::OP_ADDW;
          {F7_BASE, 3'b001}:   op = exu_pkg::OP_SLLW;
          {F7_BASE, 3'b101}:   op = exu_pkg::OP_SRLW;
          {F7_ALT, 3'b000}:    op = exu_pkg::OP_SUBW;
          {F7_ALT, 3'b101}:    op = exu_pkg::OP_SRAW;
          {F7_MULDIV, 3'b000}: op = exu_pkg::OP_MULW;
          {F7_MULDIV, 3'b100}: op = exu_pkg::OP_DIVW;
          {F7_MULDIV, 3'b101}: op = exu_pkg::OP_DIVUW;
          {F7_MULDIV, 3'b110}: op = exu_pkg::OP_REMW;
          {F7_MULDIV, 3'b111}: op = exu_pkg::OP_REMUW;
          default:             op = exu_pkg::OP_NOP;
        endcase
      end
      isa_pkg::OPC_OP_IMM_32: begin
        src = exu_pkg::SEL_IMM;
        imm = shamt5;
        if (i_inst.funct3 == 3'b000) begin
          op  = exu_pkg::OP_ADDW;
          imm = imm_i;
        end else if (i_inst.funct7 == F7_BASE && i_inst.funct3 == 3'b001) begin
          op = exu_pkg::OP_SLLW;
        end else if (i_inst.funct7 == F7_BASE && i_inst.funct3 == 3'b101) begin
          op = exu_pkg::OP_SRLW;
        end else if (i_inst.funct7 == F7_ALT && i_inst.funct3 == 3'b101) begin
          op = exu_pkg::OP_SRAW;
        end
      end
      isa_pkg::OPC_LUI: begin
        src = exu_pkg::SEL_LUI;
        op  = exu_pkg::OP_ADD;
        imm = imm_u;
      end
      isa_pkg::OPC_AUIPC: begin
        src = exu_pkg::SEL_PCI;
        op  = exu_pkg::OP_ADD;
        imm = imm_u;
      end
      isa_pkg::OPC_JAL: begin
        src = exu_pkg::SEL_PC4;
        op  = exu_pkg::OP_ADD;
        imm = imm_j;   // Target offset, the result is only the link value
      end
      isa_pkg::OPC_JALR: begin
        if (i_inst.funct3 == 3'b000) begin
          src = exu_pkg::SEL_PC4;
          op  = exu_pkg::OP_ADD;
          imm = imm_i;
        end
      end
      default: begin
        op = exu_pkg::OP_NOP;
      end
    endcase
  end

  assign o_req = '{
    src: src,
    op:  op,
    imm: imm,
    rd:  i_inst.rd,
    wen: (op != exu_pkg::OP_NOP) && (i_inst.rd != 5'd0)
  };

endmodule

//--- design/exu_logic.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module exu_logic (
  input  isa_pkg::word_t    i_pc,
  input  isa_pkg::word_t    i_rs1,
  input  isa_pkg::word_t    i_rs2,
  input  isa_pkg::word_t    i_imm,
  input  exu_pkg::exu_src_e i_exsrc,
  input  exu_pkg::exu_op_e  i_exopt,
  output isa_pkg::word_t    o_exu_res
);

  localparam int XLEN   = `CPU_WIDTH;
  localparam int NR_SRC = 5;

  isa_pkg::word_t           src1;
  isa_pkg::word_t           src2;
  logic                     mul_a_signed;
  logic                     mul_b_signed;
  logic signed [XLEN:0]     mul_a;
  logic signed [XLEN:0]     mul_b;
  logic signed [2*XLEN+1:0] prod;
  logic                     slt;
  isa_pkg::word_t           sra64;
  logic [31:0]              a32;
  logic [31:0]              b32;
  logic [31:0]              sraw;
  logic                     div_zero;
  logic                     div_ovf;
  logic                     divw_zero;
  logic                     divw_ovf;
  isa_pkg::word_t           quot_s;
  isa_pkg::word_t           rem_s;
  isa_pkg::word_t           quot_u;
  isa_pkg::word_t           rem_u;
  logic [31:0]              quot_w;
  logic [31:0]              rem_w;
  logic [31:0]              quot_wu;
  logic [31:0]              rem_wu;

  function automatic isa_pkg::word_t sext32(input logic [31:0] v);
    return {{(XLEN-32){v[31]}}, v};
  endfunction

  stl_mux_default #(
    .NR_KEY   (NR_SRC),
    .KEY_LEN  (`EXU_SEL_WIDTH),
    .DATA_LEN (XLEN)
  ) mux_src1 (
    .o_out     (src1),
    .i_key     (i_exsrc),
    .i_default ({XLEN{1'b0}}),
    .i_lut     ({
      exu_pkg::SEL_REG, i_rs1,
      exu_pkg::SEL_IMM, i_rs1,
      exu_pkg::SEL_PC4, i_pc,
      exu_pkg::SEL_PCI, i_pc,
      exu_pkg::SEL_LUI, {XLEN{1'b0}}
    })
  );

  stl_mux_default #(
    .NR_KEY   (NR_SRC),
    .KEY_LEN  (`EXU_SEL_WIDTH),
    .DATA_LEN (XLEN)
  ) mux_src2 (
    .o_out     (src2),
    .i_key     (i_exsrc),
    .i_default ({XLEN{1'b0}}),
    .i_lut     ({
      exu_pkg::SEL_REG, i_rs2,
      exu_pkg::SEL_IMM, i_imm,
      exu_pkg::SEL_PC4, XLEN'(4),
      exu_pkg::SEL_PCI, i_imm,
      exu_pkg::SEL_LUI, i_imm
    })
  );

  // One 65x65 multiplier, the extra top bit picks the signedness of each side
  assign mul_a_signed = (i_exopt == exu_pkg::OP_MULH) || (i_exopt == exu_pkg::OP_MULHSU);
  assign mul_b_signed = (i_exopt == exu_pkg::OP_MULH);
  assign mul_a        = {mul_a_signed & src1[XLEN-1], src1};
  assign mul_b        = {mul_b_signed & src2[XLEN-1], src2};
  assign prod         = mul_a * mul_b;

  assign slt   = $signed(src1) < $signed(src2);
  assign sra64 = $signed(src1) >>> src2[5:0];
  assign a32   = src1[31:0];
  assign b32   = src2[31:0];
  assign sraw  = $signed(a32) >>> src2[4:0];

  assign div_zero  = (src2 == '0);
  assign div_ovf   = (src1 == {1'b1, {(XLEN-1){1'b0}}}) && (src2 == '1);
  assign divw_zero = (b32 == '0);
  assign divw_ovf  = (a32 == 32'h8000_0000) && (b32 == '1);

  assign quot_s  = $signed(src1) / $signed(src2);
  assign rem_s   = $signed(src1) % $signed(src2);
  assign quot_u  = src1 / src2;
  assign rem_u   = src1 % src2;
  assign quot_w  = $signed(a32) / $signed(b32);
  assign rem_w   = $signed(a32) % $signed(b32);
  assign quot_wu = a32 / b32;
  assign rem_wu  = a32 % b32;

  always_comb begin
    case (i_exopt)
      exu_pkg::OP_ADD:    o_exu_res = src1 + src2;
      exu_pkg::OP_SUB:    o_exu_res = src1 - src2;
      exu_pkg::OP_ADDW:   o_exu_res = sext32(a32 + b32);
      exu_pkg::OP_SUBW:   o_exu_res = sext32(a32 - b32);
      exu_pkg::OP_AND:    o_exu_res = src1 & src2;
      exu_pkg::OP_OR:     o_exu_res = src1 | src2;
      exu_pkg::OP_XOR:    o_exu_res = src1 ^ src2;
      exu_pkg::OP_SLL:    o_exu_res = src1 << src2[5:0];
      exu_pkg::OP_SRL:    o_exu_res = src1 >> src2[5:0];
      exu_pkg::OP_SRA:    o_exu_res = sra64;
      exu_pkg::OP_SLLW:   o_exu_res = sext32(a32 << src2[4:0]);
      exu_pkg::OP_SRLW:   o_exu_res = sext32(a32 >> src2[4:0]);
      exu_pkg::OP_SRAW:   o_exu_res = sext32(sraw);
      exu_pkg::OP_SLT:    o_exu_res = {{(XLEN-1){1'b0}}, slt};
      exu_pkg::OP_SLTU:   o_exu_res = {{(XLEN-1){1'b0}}, src1 < src2};
      exu_pkg::OP_MUL:    o_exu_res = prod[XLEN-1:0];
      exu_pkg::OP_MULH:   o_exu_res = prod[2*XLEN-1:XLEN];
      exu_pkg::OP_MULHSU: o_exu_res = prod[2*XLEN-1:XLEN];
      exu_pkg::OP_MULHU:  o_exu_res = prod[2*XLEN-1:XLEN];
      exu_pkg::OP_DIV:    o_exu_res = div_zero ? '1 : (div_ovf ? src1 : quot_s);
      exu_pkg::OP_DIVU:   o_exu_res = div_zero ? '1 : quot_u;
      exu_pkg::OP_REM:    o_exu_res = div_zero ? src1 : (div_ovf ? '0 : rem_s);
      exu_pkg::OP_REMU:   o_exu_res = div_zero ? src1 : rem_u;
      exu_pkg::OP_MULW:   o_exu_res = sext32(prod[31:0]);
      exu_pkg::OP_DIVW:   o_exu_res = sext32(divw_zero ? '1 : (divw_ovf ? a32 : quot_w));
      exu_pkg::OP_DIVUW:  o_exu_res = sext32(divw_zero ? '1 : quot_wu);
      exu_pkg::OP_REMW:   o_exu_res = sext32(divw_zero ? a32 : (divw_ovf ? '0 : rem_w));
      exu_pkg::OP_REMUW:  o_exu_res = sext32(divw_zero ? a32 : rem_wu);
      default:            o_exu_res = '0;   // NOP and anything unknown
    endcase
  end

endmodule

//--- design/exu_top.sv
`timescale 1ns/100ps

module exu_top (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_valid,
  input  isa_pkg::inst_t    i_inst,
  input  isa_pkg::word_t    i_pc,
  input  isa_pkg::word_t    i_rs1,
  input  isa_pkg::word_t    i_rs2,
  output logic              o_valid,
  output isa_pkg::reg_idx_t o_rd,
  output logic              o_wen,
  output isa_pkg::word_t    o_res
);

  exu_pkg::exu_req_t req;
  isa_pkg::word_t    exu_res;

  idu_decode idu_decode_i (
    .i_inst (i_inst),
    .o_req  (req)
  );

  exu_logic exu_logic_i (
    .i_pc      (i_pc),
    .i_rs1     (i_rs1),
    .i_rs2     (i_rs2),
    .i_imm     (req.imm),
    .i_exsrc   (req.src),
    .i_exopt   (req.op),
    .o_exu_res (exu_res)
  );

  // Single result stage, a strobe at one edge is visible after the next
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
      o_wen   <= 1'b0;
      o_res   <= '0;
    end else begin
      o_valid <= i_valid;
      if (i_valid) begin
        o_wen <= req.wen;
        o_res <= exu_res;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_rd <= req.rd;
    end
  end

endmodule

//--- bench/exu_top_checker.sv
`timescale 1ns/100ps

module exu_top_checker (
  input logic       i_clk,
  input logic       i_rst,
  input logic       i_valid,
  input logic       o_valid,
  input logic       o_wen,
  input logic [4:0] o_rd
);

  // A strobe at one edge shows up as o_valid right after the next edge
  valid_follows_strobe: assert property (
    @(posedge i_clk) !$past(i_rst) |-> (o_valid == $past(i_valid))
  ) else $error("o_valid does not follow the previous cycle's i_valid");

  valid_low_after_reset: assert property (
    @(posedge i_clk) $past(i_rst) |-> !o_valid
  ) else $error("o_valid is high in the cycle after reset");

  // x0 is never written
  no_write_to_x0: assert property (
    @(posedge i_clk) o_wen |-> (o_rd != 5'd0)
  ) else $error("o_wen is high while o_rd is zero");

endmodule

bind exu_top exu_top_checker exu_top_checker_i (
  .i_clk   (i_clk),
  .i_rst   (i_rst),
  .i_valid (i_valid),
  .o_valid (o_valid),
  .o_wen   (o_wen),
  .o_rd    (o_rd)
);

//--- bench/tb_exu_top.sv
`timescale 1ns/100ps

module tb_exu_top;

  localparam logic [6:0] OP    = 7'h33;
  localparam logic [6:0] OPI   = 7'h13;
  localparam logic [6:0] OP32  = 7'h3b;
  localparam logic [6:0] OPI32 = 7'h1b;
  localparam logic [63:0] MIN  = 64'h8000_0000_0000_0000;
  localparam logic [63:0] ONES = 64'hffff_ffff_ffff_ffff;
  localparam int TIMEOUT = 20;
  localparam int NR_RANDOM = 60;

  typedef struct packed {
    logic [31:0] inst;
    logic [63:0] pc;
    logic [63:0] rs1;
    logic [63:0] rs2;
    logic [63:0] res;
    logic        wen;
  } vec_t;

  logic        i_clk;
  logic        i_rst;
  logic        i_valid;
  logic [31:0] i_inst;
  logic [63:0] i_pc;
  logic [63:0] i_rs1;
  logic [63:0] i_rs2;
  logic        o_valid;
  logic [4:0]  o_rd;
  logic        o_wen;
  logic [63:0] o_res;

  vec_t  vecs[$];
  string names[$];
  int    n_pass;
  int    n_fail;

  exu_top exu_top_i (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (i_valid),
    .i_inst  (i_inst),
    .i_pc    (i_pc),
    .i_rs1   (i_rs1),
    .i_rs2   (i_rs2),
    .o_valid (o_valid),
    .o_rd    (o_rd),
    .o_wen   (o_wen),
    .o_res   (o_res)
  );

  always #5 i_clk = ~i_clk;

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [63:0] sx(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  // Reference model for the OP and OP-32 register forms returning {supported, result}
  function automatic logic [64:0] ref_rtype(input logic [31:0] inst, input logic [63:0] a,
                                            input logic [63:0] b);
    logic [127:0] p;
    logic [31:0]  a32;
    logic [31:0]  b32;
    logic [31:0]  r32;
    logic [63:0]  r;
    logic         ok;
    a32 = a[31:0];
    b32 = b[31:0];
    r   = '0;
    r32 = '0;
    ok  = 1'b1;
    if (inst[6:0] == OP) begin
      case ({inst[31:25], inst[14:12]})
        {7'h00, 3'd0}: r = a + b;
        {7'h00, 3'd1}: r = a << b[5:0];
        {7'h00, 3'd2}: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        {7'h00, 3'd3}: r = (a < b) ? 64'd1 : 64'd0;
        {7'h00, 3'd4}: r = a ^ b;
        {7'h00, 3'd5}: r = a >> b[5:0];
        {7'h00, 3'd6}: r = a | b;
        {7'h00, 3'd7}: r = a & b;
        {7'h20, 3'd0}: r = a - b;
        {7'h20, 3'd5}: r = $signed(a) >>> b[5:0];
        {7'h01, 3'd0}: r = a * b;
        {7'h01, 3'd1}: begin
          p = $signed({{64{a[63]}}, a}) * $signed({{64{b[63]}}, b});
          r = p[127:64];
        end
        {7'h01, 3'd2}: begin
          p = {{64{a[63]}}, a} * {64'd0, b};   // Low 128 bits are sign-agnostic
          r = p[127:64];
        end
        {7'h01, 3'd3}: begin
          p = {64'd0, a} * {64'd0, b};
          r = p[127:64];
        end
        {7'h01, 3'd4}: begin
          if (b == 0) r = ONES;
          else if (a == MIN && b == ONES) r = a;
          else r = $signed(a) / $signed(b);
        end
        {7'h01, 3'd5}: r = (b == 0) ? ONES : a / b;
        {7'h01, 3'd6}: begin
          if (b == 0) r = a;
          else if (a == MIN && b == ONES) r = '0;
          else r = $signed(a) % $signed(b);
        end
        {7'h01, 3'd7}: r = (b == 0) ? a : a % b;
        default: ok = 1'b0;
      endcase
    end else begin
      case ({inst[31:25], inst[14:12]})
        {7'h00, 3'd0}: r32 = a32 + b32;
        {7'h00, 3'd1}: r32 = a32 << b[4:0];
        {7'h00, 3'd5}: r32 = a32 >> b[4:0];
        {7'h20, 3'd0}: r32 = a32 - b32;
        {7'h20, 3'd5}: r32 = $signed(a32) >>> b[4:0];
        {7'h01, 3'd0}: r32 = a32 * b32;
        {7'h01, 3'd4}: begin
          if (b32 == 0) r32 = '1;
          else if (a32 == 32'h8000_0000 && b32 == '1) r32 = a32;
          else r32 = $signed(a32) / $signed(b32);
        end
        {7'h01, 3'd5}: r32 = (b32 == 0) ? '1 : a32 / b32;
        {7'h01, 3'd6}: begin
          if (b32 == 0) r32 = a32;
          else if (a32 == 32'h8000_0000 && b32 == '1) r32 = '0;
          else r32 = $signed(a32) % $signed(b32);
        end
        {7'h01, 3'd7}: r32 = (b32 == 0) ? a32 : a32 % b32;
        default: ok = 1'b0;
      endcase
      r = ok ? sx(r32) : 64'd0;
    end
    return {ok, r};
  endfunction

  task automatic add(input string name, input logic [31:0] inst, input logic [63:0] pc,
                     input logic [63:0] rs1, input logic [63:0] rs2,
                     input logic [63:0] res, input logic wen);
    vecs.push_back('{inst: inst, pc: pc, rs1: rs1, rs2: rs2, res: res, wen: wen});
    names.push_back(name);
  endtask

  task automatic drive(input vec_t v);
    i_valid = 1'b1;
    i_inst  = v.inst;
    i_pc    = v.pc;
    i_rs1   = v.rs1;
    i_rs2   = v.rs2;
  endtask

  task automatic check_result(input vec_t e, output bit ok);
    int cycles;
    ok     = 1'b1;
    cycles = 0;
    @(posedge i_clk);
    #1;
    while (!o_valid && cycles < TIMEOUT) begin
      @(posedge i_clk);
      #1;
      cycles++;
    end
    if (!o_valid) begin
      $display("ERROR: no result appeared within %0d cycles", TIMEOUT);
      ok = 1'b0;
    end else begin
      assert (cycles == 0) else begin
        $display("ERROR: result arrived %0d cycles late", cycles);
        ok = 1'b0;
      end
      assert (o_res === e.res) else begin
        $display("MISMATCH t=%0t o_res exp=%h got=%h", $time, e.res, o_res);
        ok = 1'b0;
      end
      assert (o_rd === e.inst[11:7]) else begin
        $display("MISMATCH t=%0t o_rd exp=%0d got=%0d", $time, e.inst[11:7], o_rd);
        ok = 1'b0;
      end
      assert (o_wen === e.wen) else begin
        $display("MISMATCH t=%0t o_wen exp=%b got=%b", $time, e.wen, o_wen);
        ok = 1'b0;
      end
    end
  endtask

  task automatic check_idle(input string name, input int cycles, input bit cleared);
    bit ok;
    ok = 1'b1;
    repeat (cycles) begin
      @(posedge i_clk);
      #1;
      assert (o_valid === 1'b0) else begin
        $display("MISMATCH t=%0t o_valid exp=0 got=%b", $time, o_valid);
        ok = 1'b0;
      end
      if (cleared) begin   // Reset values hold until the first strobe loads the outputs
        assert (o_wen === 1'b0) else begin
          $display("MISMATCH t=%0t o_wen exp=0 got=%b", $time, o_wen);
          ok = 1'b0;
        end
        assert (o_res === 64'd0) else begin
          $display("MISMATCH t=%0t o_res exp=0 got=%h", $time, o_res);
          ok = 1'b0;
        end
      end
    end
    if (ok) n_pass++;
    else n_fail++;
    $display("test %-10s %s", name, ok ? "ok" : "FAILED");
  endtask

  task automatic fill_table();
    add("add", enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd1, OP), 0, 5, 7, 12, 1);
    add("sub", enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd2, OP), 0, 5, 7, 64'hffff_ffff_ffff_fffe, 1);
    add("sra", enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd3, OP), 0, MIN, 4, 64'hf800_0000_0000_0000, 1);
    add("addi", enc_i(12'hfff, 5'd1, 3'd0, 5'd4, OPI), 0, 10, 0, 9, 1);
    add("srai63", enc_i({6'h10, 6'd63}, 5'd1, 3'd5, 5'd5, OPI), 0, MIN, 0, ONES, 1);
    add("slli40", enc_i({6'h00, 6'd40}, 5'd1, 3'd1, 5'd6, OPI), 0, 1, 0, 64'h100_0000_0000, 1);
    add("slti", enc_i(12'd1, 5'd1, 3'd2, 5'd7, OPI), 0, ONES, 0, 1, 1);
    add("sltiu", enc_i(12'd1, 5'd1, 3'd3, 5'd8, OPI), 0, ONES, 0, 0, 1);
    add("andi", enc_i(12'h0ff, 5'd1, 3'd7, 5'd9, OPI), 0, 64'h1234, 0, 64'h34, 1);
    add("addw", enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd10, OP32), 0, 64'h7fff_ffff, 1,
        64'hffff_ffff_8000_0000, 1);
    add("subw", enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd11, OP32), 0, 0, 1, ONES, 1);
    add("sllw", enc_r(7'h00, 5'd2, 5'd1, 3'd1, 5'd12, OP32), 0, 1, 31,
        64'hffff_ffff_8000_0000, 1);
    add("srlw", enc_r(7'h00, 5'd2, 5'd1, 3'd5, 5'd13, OP32), 0, 64'hffff_ffff_8000_0000, 4,
        64'h0800_0000, 1);
    add("sraw", enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd14, OP32), 0, 64'h8000_0000, 4,
        64'hffff_ffff_f800_0000, 1);
    add("addiw", enc_i(12'd1, 5'd1, 3'd0, 5'd15, OPI32), 0, 64'h7fff_ffff, 0,
        64'hffff_ffff_8000_0000, 1);
    add("mul", enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd16, OP), 0, 3, 64'hffff_ffff_ffff_fffe,
        64'hffff_ffff_ffff_fffa, 1);
    add("mulh", enc_r(7'h01, 5'd2, 5'd1, 3'd1, 5'd17, OP), 0, ONES, ONES, 0, 1);
    add("mulhsu", enc_r(7'h01, 5'd2, 5'd1, 3'd2, 5'd18, OP), 0, ONES, 2, ONES, 1);
    add("mulhu", enc_r(7'h01, 5'd2, 5'd1, 3'd3, 5'd19, OP), 0, ONES, ONES,
        64'hffff_ffff_ffff_fffe, 1);
    add("div0", enc_r(7'h01, 5'd2, 5'd1, 3'd4, 5'd20, OP), 0, 7, 0, ONES, 1);
    add("rem0", enc_r(7'h01, 5'd2, 5'd1, 3'd6, 5'd21, OP), 0, 7, 0, 7, 1);
    add("divovf", enc_r(7'h01, 5'd2, 5'd1, 3'd4, 5'd22, OP), 0, MIN, ONES, MIN, 1);
    add("removf", enc_r(7'h01, 5'd2, 5'd1, 3'd6, 5'd23, OP), 0, MIN, ONES, 0, 1);
    add("divu", enc_r(7'h01, 5'd2, 5'd1, 3'd5, 5'd24, OP), 0, ONES, 2,
        64'h7fff_ffff_ffff_ffff, 1);
    add("remu", enc_r(7'h01, 5'd2, 5'd1, 3'd7, 5'd25, OP), 0, 10, 3, 1, 1);
    add("divneg", enc_r(7'h01, 5'd2, 5'd1, 3'd4, 5'd26, OP), 0, -64'sd7, 2,
        64'hffff_ffff_ffff_fffd, 1);
    add("remneg", enc_r(7'h01, 5'd2, 5'd1, 3'd6, 5'd27, OP), 0, -64'sd7, 2, ONES, 1);
    add("divwovf", enc_r(7'h01, 5'd2, 5'd1, 3'd4, 5'd28, OP32), 0, 64'h8000_0000,
        64'hffff_ffff, 64'hffff_ffff_8000_0000, 1);
    add("remuw0", enc_r(7'h01, 5'd2, 5'd1, 3'd7, 5'd29, OP32), 0, 64'h1_8000_0001, 0,
        64'hffff_ffff_8000_0001, 1);
    add("lui", enc_u(20'h80000, 5'd5, 7'h37), 0, 0, 0, 64'hffff_ffff_8000_0000, 1);
    add("auipc", enc_u(20'h00001, 5'd6, 7'h17), 64'h1000, 0, 0, 64'h2000, 1);
    add("jal", enc_u(20'h12345, 5'd1, 7'h6f), 64'h2000, 0, 0, 64'h2004, 1);
    add("jalr", enc_i(12'h010, 5'd3, 3'd0, 5'd1, 7'h67), 64'h3000, 64'h99, 0, 64'h3004, 1);
    add("rd0", enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0, OP), 0, 5, 7, 12, 0);
    add("unsup", enc_i(12'd0, 5'd1, 3'd3, 5'd3, 7'h03), 0, 5, 7, 0, 0);
  endtask

  task automatic fill_random();
    logic [6:0]  f7;
    logic [31:0] inst;
    logic [63:0] a;
    logic [63:0] b;
    logic [64:0] r;
    for (int k = 0; k < NR_RANDOM; k++) begin
      case ($urandom % 3)
        0: f7 = 7'h00;
        1: f7 = 7'h20;
        default: f7 = 7'h01;
      endcase
      inst = enc_r(f7, 5'($urandom), 5'($urandom), 3'($urandom), 5'($urandom),
                   ($urandom % 2) ? OP : OP32);
      a = {$urandom, $urandom};
      b = ($urandom % 8 == 0) ? 64'd0 : {$urandom, $urandom};
      r = ref_rtype(inst, a, b);
      add($sformatf("rand%0d", k), inst, 0, a, b, r[63:0], r[64] && inst[11:7] != 0);
    end
  endtask

  initial begin
    bit ok;
    i_clk   = 1'b0;
    i_rst   = 1'b1;
    i_valid = 1'b0;
    i_inst  = '0;
    i_pc    = '0;
    i_rs1   = '0;
    i_rs2   = '0;
    n_pass  = 0;
    n_fail  = 0;
    void'($urandom(32'hf6dd_aedf));
    fill_table();
    fill_random();

    // A strobe held through reset must not reach the outputs
    drive(vecs[0]);
    check_idle("reset", 4, 1'b1);
    i_rst   = 1'b0;
    i_valid = 1'b0;
    check_idle("idle", 3, 1'b1);

    // Each back-to-back strobe has its result checked one cycle after its input
    drive(vecs[0]);
    for (int k = 0; k < vecs.size(); k++) begin
      check_result(vecs[k], ok);
      if (k + 1 < vecs.size()) drive(vecs[k + 1]);
      else i_valid = 1'b0;
      if (ok) n_pass++;
      else n_fail++;
      $display("test %-10s %s", names[k], ok ? "ok" : "FAILED");
    end
    check_idle("drain", 3, 1'b0);

    $display("tests %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+design
design/isa_pkg.sv
design/exu_pkg.sv
design/stl_mux_default.sv
design/idu_decode.sv
design/exu_logic.sv
design/exu_top.sv
bench/exu_top_checker.sv
bench/tb_exu_top.sv
